// ==== bar_read_return.sv ====
// ====================
// Read return merge
// ====================

`default_nettype none

`include "cfg_bridge_settings.svh"

module bar_read_return #(
   parameter int                 NUM_BAR    = `CB_NUM_BAR,
   parameter logic [NUM_BAR-1:0] BAR_ENABLE = `CB_BAR_ENABLE
) (
   input  cfg_bridge_pkg::rxm_rd_t rxm_rd_i [NUM_BAR],
   output cfg_bridge_pkg::rxm_rd_t rd_ret_o
);

   import cfg_bridge_pkg::*;

   logic [NUM_BAR-1:0]        vld;
   logic [`CB_RXM_DATA_W-1:0] data_or;
   logic                      one_hot;
   rxm_rd_t                   ret;

   // Absent ports never return data
   always_comb
   begin
      data_or = '0;
      for (int i = 0; i < NUM_BAR; i++)
      begin
         vld[i] = rxm_rd_i[i].valid & BAR_ENABLE[i];
         if (vld[i])
         begin
            data_or = data_or | rxm_rd_i[i].data;
         end
      end
   end

   // No arbitration, overlapping returns give zero data
   assign one_hot = (vld != '0) && ((vld & (vld - 1'b1)) == '0);

   always_comb
   begin
      ret.valid = |vld;
      ret.data  = one_hot ? data_or : '0;
   end

   assign rd_ret_o = ret;

endmodule

`default_nettype wire

// ==== cfg_bridge_assert.sv ====
// ====================
// Bridge assertions
// ====================

`default_nettype none

`include "cfg_bridge_settings.svh"

module cfg_bridge_assert (
   input logic                       AvlClk_i,
   input cfg_bridge_pkg::rxm_rd_t    rxm_rd_i [`CB_NUM_BAR],
   input cfg_bridge_pkg::rxm_rd_t    rd_ret_i,
   input logic [15:0]                msi_control_i,
   input cfg_bridge_pkg::msi_intfc_t msi_intfc_i
);

   import cfg_bridge_pkg::*;

   localparam logic [`CB_NUM_BAR-1:0] BAR_EN = `CB_BAR_ENABLE;

   logic [`CB_NUM_BAR-1:0] en_vld;   // Valids of ports that exist

   always_comb
   begin
      for (int i = 0; i < `CB_NUM_BAR; i++)
      begin
         en_vld[i] = rxm_rd_i[i].valid & BAR_EN[i];
      end
   end

   a_msi_en: assert property (@(posedge AvlClk_i)
      msi_control_i[0] == msi_intfc_i.msi_en)
      else $error("MSI enable in the interface word differs from MSI control bit 0");

   a_ret_src: assert property (@(posedge AvlClk_i)
      rd_ret_i.valid |-> (en_vld != '0))
      else $error("Read return valid without any enabled port valid");

   // Idle return must carry no stale data
   a_ret_idle: assert property (@(posedge AvlClk_i)
      !rd_ret_i.valid |-> (rd_ret_i.data == '0))
      else $error("Read return data nonzero while valid is low");

endmodule

bind cfg_bridge_top cfg_bridge_assert u_assert (
   .AvlClk_i      (AvlClk_i),
   .rxm_rd_i      (rxm_rd_i),
   .rd_ret_i      (rd_ret_o),
   .msi_control_i (msi_control_o),
   .msi_intfc_i   (msi_intfc_o)
);

`default_nettype wire

// ==== cfg_bridge_pkg.sv ====
// ====================
// Bridge types
// ====================

`default_nettype none

`include "cfg_bridge_settings.svh"

package cfg_bridge_pkg;

   // Retimed selector and data pair from the core
   typedef struct packed {
      logic [`CB_CFG_ADDR_W-1:0] sel;
      logic [`CB_CFG_DATA_W-1:0] data;
   } cfg_tap_t;

   // Shadow copy of the configuration space fields
   typedef struct packed {
      logic [12:0] bus_dev;     // Bus and device number
      logic [31:0] dev_csr;
      logic [15:0] msi_ena;     // MSI control, bit 0 is MSI enable
      logic [15:0] msix_ctrl;
      logic [15:0] prmcsr;      // Command register, bit 2 is bus master enable
      logic [63:0] msi_addr;
      logic [15:0] msi_data;
   } cfg_shadow_t;

   // 82-bit MSI interface word
   typedef struct packed {
      logic        master_en;   // Bit 81
      logic        msi_en;      // Bit 80
      logic [15:0] msi_data;
      logic [63:0] msi_addr;
   } msi_intfc_t;

   // One read return from a BAR-window master
   typedef struct packed {
      logic                      valid;
      logic [`CB_RXM_DATA_W-1:0] data;
   } rxm_rd_t;

endpackage

`default_nettype wire

// ==== cfg_bridge_settings.svh ====
// ====================
// Bridge settings
// ====================

`ifndef CFG_BRIDGE_SETTINGS_SVH
`define CFG_BRIDGE_SETTINGS_SVH

// BAR-window read return ports
`define CB_NUM_BAR     6
`define CB_RXM_DATA_W  64
`define CB_BAR_ENABLE  6'b010101   // Ports with a nonzero BAR size

// Configuration tap
`define CB_CFG_ADDR_W  4
`define CB_CFG_DATA_W  32

// Selector codes presented by the core
`define CB_SEL_DEVCSR     4'd0
`define CB_SEL_PRMCSR     4'd3
`define CB_SEL_MSIADDR_A  4'd5    // Address bits 11..0
`define CB_SEL_MSIADDR_C  4'd6    // Address bits 43..32
`define CB_SEL_MSIADDR_B  4'd9    // Address bits 31..12
`define CB_SEL_MSIADDR_D  4'd11   // Address bits 63..44
`define CB_SEL_MSICTL     4'd13
`define CB_SEL_BUSDEV     4'd15

`endif

// ==== cfg_bridge_top.sv ====
// ====================
// Config bridge top
// ====================

`default_nettype none

`include "cfg_bridge_settings.svh"

module cfg_bridge_top (
   input  logic                        AvlClk_i,
   input  logic                        Rstn_i,
   input  logic [`CB_CFG_ADDR_W-1:0]   cfg_addr_i,
   input  logic [`CB_CFG_DATA_W-1:0]   cfg_ctl_i,
   input  cfg_bridge_pkg::rxm_rd_t     rxm_rd_i [`CB_NUM_BAR],
   output cfg_bridge_pkg::rxm_rd_t     rd_ret_o,
   output logic [12:0]                 bus_dev_o,
   output logic                        master_en_o,
   output logic [31:0]                 dev_csr_o,
   output logic [15:0]                 msi_control_o,
   output logic [15:0]                 msix_control_o,
   output cfg_bridge_pkg::msi_intfc_t  msi_intfc_o
);

   import cfg_bridge_pkg::*;

   logic        rstn_sync;
   cfg_tap_t    cfg_tap;
   cfg_shadow_t shadow;

   cfg_ingress u_ingress (
      .AvlClk_i    (AvlClk_i),
      .Rstn_i      (Rstn_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_ctl_i   (cfg_ctl_i),
      .rstn_sync_o (rstn_sync),
      .cfg_tap_o   (cfg_tap)
   );

   // Shadow runs on the raw reset, not the synchronized one
   cfg_shadow u_shadow (
      .AvlClk_i  (AvlClk_i),
      .Rstn_i    (Rstn_i),
      .cfg_tap_i (cfg_tap),
      .shadow_o  (shadow)
   );

   msi_out_stage u_msi_out (
      .AvlClk_i       (AvlClk_i),
      .rstn_sync_i    (rstn_sync),
      .shadow_i       (shadow),
      .dev_csr_o      (dev_csr_o),
      .msi_control_o  (msi_control_o),
      .msix_control_o (msix_control_o),
      .msi_intfc_o    (msi_intfc_o)
   );

   bar_read_return #(
      .NUM_BAR    (`CB_NUM_BAR),
      .BAR_ENABLE (`CB_BAR_ENABLE)
   ) u_rd_ret (
      .rxm_rd_i (rxm_rd_i),
      .rd_ret_o (rd_ret_o)
   );

   assign bus_dev_o   = shadow.bus_dev;     // Requester ID for outgoing TLPs
   assign master_en_o = shadow.prmcsr[2];

endmodule

`default_nettype wire

// ==== cfg_ingress.sv ====
// ====================
// Config tap ingress
// ====================

`default_nettype none

`include "cfg_bridge_settings.svh"

module cfg_ingress (
   input  logic                      AvlClk_i,
   input  logic                      Rstn_i,
   input  logic [`CB_CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [`CB_CFG_DATA_W-1:0] cfg_ctl_i,
   output logic                      rstn_sync_o,
   output cfg_bridge_pkg::cfg_tap_t  cfg_tap_o
);

   import cfg_bridge_pkg::*;

   logic     rstn_meta;
   logic     rstn_sync;
   cfg_tap_t tap_q;

   // Asserts with Rstn_i, releases on the second edge after it rises
   always_ff @(posedge AvlClk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         rstn_meta <= 1'b0;
         rstn_sync <= 1'b0;
      end
      else
      begin
         rstn_meta <= 1'b1;
         rstn_sync <= rstn_meta;
      end
   end

   assign rstn_sync_o = rstn_sync;

   // The core drives the pair every cycle with no strobe,
   // so it is simply retimed here
   always_ff @(posedge AvlClk_i or negedge rstn_sync)
   begin
      if (!rstn_sync)
      begin
         tap_q <= '0;
      end
      else
      begin
         tap_q.sel  <= cfg_addr_i;
         tap_q.data <= cfg_ctl_i;
      end
   end

   assign cfg_tap_o = tap_q;

endmodule

`default_nettype wire

// ==== cfg_shadow.sv ====
// ====================
// Config shadow decode
// ====================

`default_nettype none

`include "cfg_bridge_settings.svh"

module cfg_shadow (
   input  logic                        AvlClk_i,
   input  logic                        Rstn_i,
   input  cfg_bridge_pkg::cfg_tap_t    cfg_tap_i,
   output cfg_bridge_pkg::cfg_shadow_t shadow_o
);

   import cfg_bridge_pkg::*;

   cfg_shadow_t shadow_q;
   logic [`CB_CFG_DATA_W-1:0] dat;

   assign dat = cfg_tap_i.data;

   // Each selector code loads only its own fields, other codes hold
   always_ff @(posedge AvlClk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         shadow_q <= '0;
      end
      else
      begin
         case (cfg_tap_i.sel)
            `CB_SEL_BUSDEV:
            begin
               shadow_q.bus_dev  <= dat[12:0];
               shadow_q.msi_data <= dat[31:16];   // Shares the code with bus/device
            end
            `CB_SEL_DEVCSR:
            begin
               shadow_q.dev_csr <= {16'h0, dat[31:16]};
            end
            `CB_SEL_MSICTL:
            begin
               shadow_q.msi_ena   <= dat[15:0];
               shadow_q.msix_ctrl <= dat[31:16];
            end
            `CB_SEL_PRMCSR:
            begin
               shadow_q.prmcsr <= dat[23:8];
            end
            // MSI address arrives in four slices
            `CB_SEL_MSIADDR_A:
            begin
               shadow_q.msi_addr[11:0] <= dat[31:20];
            end
            `CB_SEL_MSIADDR_B:
            begin
               shadow_q.msi_addr[31:12] <= dat[31:12];
            end
            `CB_SEL_MSIADDR_C:
            begin
               shadow_q.msi_addr[43:32] <= dat[31:20];
            end
            `CB_SEL_MSIADDR_D:
            begin
               shadow_q.msi_addr[63:44] <= dat[31:12];
            end
            default:
            begin
               shadow_q <= shadow_q;
            end
         endcase
      end
   end

   assign shadow_o = shadow_q;

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
cfg_bridge_pkg.sv
cfg_ingress.sv
cfg_shadow.sv
msi_out_stage.sv
bar_read_return.sv
cfg_bridge_top.sv
cfg_bridge_assert.sv
tb_cfg_bridge.sv

// ==== msi_out_stage.sv ====
// ====================
// MSI output stage
// ====================

`default_nettype none

module msi_out_stage (
   input  logic                        AvlClk_i,
   input  logic                        rstn_sync_i,
   input  cfg_bridge_pkg::cfg_shadow_t shadow_i,
   output logic [31:0]                 dev_csr_o,
   output logic [15:0]                 msi_control_o,
   output logic [15:0]                 msix_control_o,
   output cfg_bridge_pkg::msi_intfc_t  msi_intfc_o
);

   import cfg_bridge_pkg::*;

   logic [31:0] dev_csr_q;
   logic [15:0] msi_ena_q;
   logic [15:0] msix_ctrl_q;
   logic [63:0] msi_addr_q;
   logic [15:0] msi_data_q;
   msi_intfc_t  intfc;

   always_ff @(posedge AvlClk_i or negedge rstn_sync_i)
   begin
      if (!rstn_sync_i)
      begin
         dev_csr_q   <= '0;
         msi_ena_q   <= '0;
         msix_ctrl_q <= '0;
         msi_addr_q  <= '0;
         msi_data_q  <= '0;
      end
      else
      begin
         dev_csr_q   <= shadow_i.dev_csr;
         msi_ena_q   <= shadow_i.msi_ena;
         msix_ctrl_q <= shadow_i.msix_ctrl;
         msi_addr_q  <= shadow_i.msi_addr;
         msi_data_q  <= shadow_i.msi_data;
      end
   end

   // Master enable skips the output register and leads the rest by a cycle
   always_comb
   begin
      intfc.master_en = shadow_i.prmcsr[2];
      intfc.msi_en    = msi_ena_q[0];
      intfc.msi_data  = msi_data_q;
      intfc.msi_addr  = msi_addr_q;
   end

   assign msi_intfc_o    = intfc;
   assign dev_csr_o      = dev_csr_q;
   assign msi_control_o  = msi_ena_q;
   assign msix_control_o = msix_ctrl_q;   // MSI-X control word

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the configuration bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_cfg_bridge -o sim_cfg_bridge
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_cfg_bridge)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
   exit 0
fi
exit 1

// ==== tb_cfg_bridge.sv ====
// ====================
// Bridge testbench
// ====================

`default_nettype none

`include "cfg_bridge_settings.svh"

module tb_cfg_bridge;

   import cfg_bridge_pkg::*;

   localparam int TEST_CYCLES = 600;                    // Rough length of all tests
   localparam int MAX_CYCLES  = 3 * TEST_CYCLES + 200;
   localparam logic [`CB_NUM_BAR-1:0] BAR_EN = `CB_BAR_ENABLE;

   logic                      AvlClk_i;
   logic                      Rstn_i;
   logic [`CB_CFG_ADDR_W-1:0] cfg_addr;
   logic [`CB_CFG_DATA_W-1:0] cfg_ctl;
   rxm_rd_t                   rxm_rd [`CB_NUM_BAR];
   rxm_rd_t                   rd_ret;
   logic [12:0]               bus_dev;
   logic                      master_en;
   logic [31:0]               dev_csr;
   logic [15:0]               msi_control;
   logic [15:0]               msix_control;
   msi_intfc_t                msi_intfc;

   // Model, one copy per DUT pipeline stage
   logic        m_meta;
   logic        m_sync;
   cfg_tap_t    m_tap;
   cfg_shadow_t m_shd;
   cfg_shadow_t m_out;     // Only the fields of the output stage are used

   logic [3:0] used_codes [8]   = '{4'd0, 4'd3, 4'd5, 4'd6, 4'd9, 4'd11, 4'd13, 4'd15};
   logic [3:0] unused_codes [8] = '{4'd1, 4'd2, 4'd4, 4'd7, 4'd8, 4'd10, 4'd12, 4'd14};

   int cycles = 0;
   int checks = 0;
   int errors = 0;
   int test_errs = 0;
   int tests_run = 0;
   int tests_failed = 0;

   cfg_bridge_top u_dut (
      .AvlClk_i       (AvlClk_i),
      .Rstn_i         (Rstn_i),
      .cfg_addr_i     (cfg_addr),
      .cfg_ctl_i      (cfg_ctl),
      .rxm_rd_i       (rxm_rd),
      .rd_ret_o       (rd_ret),
      .bus_dev_o      (bus_dev),
      .master_en_o    (master_en),
      .dev_csr_o      (dev_csr),
      .msi_control_o  (msi_control),
      .msix_control_o (msix_control),
      .msi_intfc_o    (msi_intfc)
   );

   initial
   begin
      AvlClk_i = 1'b0;
      forever #20 AvlClk_i = ~AvlClk_i;
   end

   always @(posedge AvlClk_i)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Run timed out after %0d cycles before all tests finished", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [255:0] exp,
                            input logic [255:0] act);
      checks++;
      if (exp !== act)
      begin
         test_errs++;
         $display("** Error: %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   task automatic clear_model();
      m_meta = 1'b0;
      m_sync = 1'b0;
      m_tap  = '0;
      m_shd  = '0;
      m_out  = '0;
   endtask

   // Selector table of the configuration tap
   task automatic apply_sel(input logic [3:0] sel, input logic [31:0] d);
      case (sel)
         4'd15:
         begin
            m_shd.bus_dev  = d[12:0];
            m_shd.msi_data = d[31:16];
         end
         4'd0:  m_shd.dev_csr = {16'h0, d[31:16]};
         4'd13:
         begin
            m_shd.msi_ena   = d[15:0];
            m_shd.msix_ctrl = d[31:16];
         end
         4'd3:  m_shd.prmcsr = d[23:8];
         4'd5:  m_shd.msi_addr[11:0]  = d[31:20];
         4'd9:  m_shd.msi_addr[31:12] = d[31:12];
         4'd6:  m_shd.msi_addr[43:32] = d[31:20];
         4'd11: m_shd.msi_addr[63:44] = d[31:12];
         default: ;
      endcase
   endtask

   // Latest stage first so each stage sees the old value of the one before
   task automatic step();
      @(posedge AvlClk_i);
      if (Rstn_i)
      begin
         m_out = m_sync ? m_shd : '0;
         apply_sel(m_tap.sel, m_tap.data);
         m_tap  = m_sync ? cfg_tap_t'({cfg_addr, cfg_ctl}) : '0;
         m_sync = m_meta;
         m_meta = 1'b1;
      end
      #2;
   endtask

   function automatic logic [255:0] out_word();
      return 256'({bus_dev, master_en, dev_csr, msi_control, msix_control, msi_intfc});
   endfunction

   task automatic check_outputs(input string name);
      msi_intfc_t exp_intfc;
      rxm_rd_t    exp_ret;
      int         n;
      @(negedge AvlClk_i);
      exp_intfc = {m_shd.prmcsr[2], m_out.msi_ena[0], m_out.msi_data, m_out.msi_addr};
      n = 0;
      exp_ret = '0;
      for (int i = 0; i < `CB_NUM_BAR; i++)
      begin
         if (rxm_rd[i].valid && BAR_EN[i])
         begin
            n++;
            exp_ret.data = rxm_rd[i].data;
         end
      end
      exp_ret.valid = (n != 0);
      if (n != 1)
         exp_ret.data = '0;     // Overlap or silence returns no data
      check_val({name, " bus_dev"}, 256'(m_shd.bus_dev), 256'(bus_dev));
      check_val({name, " master_en"}, 256'(m_shd.prmcsr[2]), 256'(master_en));
      check_val({name, " dev_csr"}, 256'(m_out.dev_csr), 256'(dev_csr));
      check_val({name, " msi_control"}, 256'(m_out.msi_ena), 256'(msi_control));
      check_val({name, " msix_control"}, 256'(m_out.msix_ctrl), 256'(msix_control));
      check_val({name, " msi_intfc"}, 256'(exp_intfc), 256'(msi_intfc));
      check_val({name, " rd_ret"}, 256'(exp_ret), 256'(rd_ret));
   endtask

   task automatic check_zero(input string name);
      check_val({name, " outputs zero"}, '0, out_word());
      check_val({name, " rd_ret valid"}, '0, 256'(rd_ret.valid));
   endtask

   // Kind 0 idle, 1 one enabled, 2 one absent, 3 two enabled, 4 any mix
   task automatic drive_reads(input int kind);
      int idx;
      int jdx;
      for (int i = 0; i < `CB_NUM_BAR; i++)
      begin
         rxm_rd[i].valid = (kind == 4) && ($urandom_range(1, 0) == 1);
         rxm_rd[i].data  = {$urandom(), $urandom()};
      end
      idx = int'($urandom_range(`CB_NUM_BAR - 1, 0));
      while (BAR_EN[idx] != (kind != 2))
         idx = int'($urandom_range(`CB_NUM_BAR - 1, 0));
      jdx = int'($urandom_range(`CB_NUM_BAR - 1, 0));
      while (!BAR_EN[jdx] || jdx == idx)
         jdx = int'($urandom_range(`CB_NUM_BAR - 1, 0));
      if (kind >= 1 && kind <= 3)
         rxm_rd[idx].valid = 1'b1;
      if (kind == 3)
         rxm_rd[jdx].valid = 1'b1;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      errors += test_errs;
      if (test_errs == 0)
         $display("%-12s finished, no mismatches", name);
      else
      begin
         tests_failed++;
         $display("%-12s finished, %0d mismatches", name, test_errs);
      end
      test_errs = 0;
   endtask

   initial
   begin
      logic [255:0] snap;
      logic [3:0]   order [4];
      logic [3:0]   tmp;
      logic [63:0]  exp_addr;
      int           j;
      void'($urandom(32'h41fc_3251));
      Rstn_i   = 1'b0;
      cfg_addr = '0;
      cfg_ctl  = '0;
      drive_reads(0);
      clear_model();
      repeat (5)
      begin
         if (cycles == 3)
            Rstn_i = 1'b1;
         check_outputs("reset");
         check_zero("reset");
         step();
      end
      end_test("reset");

      repeat (120)
      begin
         cfg_addr = used_codes[$urandom_range(7, 0)];
         cfg_ctl  = $urandom();
         check_outputs("cfg_write");
         step();
      end
      end_test("cfg_write");

      cfg_addr = 4'd1;
      repeat (3)
      begin
         check_outputs("unused_sel");     // Flush the pipeline first
         step();
      end
      snap = out_word();
      repeat (60)
      begin
         cfg_addr = unused_codes[$urandom_range(7, 0)];
         cfg_ctl  = $urandom();
         check_outputs("unused_sel");
         check_val("unused_sel unchanged", snap, out_word());
         step();
      end
      end_test("unused_sel");

      for (int r = 0; r < 20; r++)
      begin
         order = '{4'd5, 4'd9, 4'd6, 4'd11};
         for (int k = 3; k > 0; k--)
         begin
            j = int'($urandom_range(k, 0));
            tmp = order[k];
            order[k] = order[j];
            order[j] = tmp;
         end
         for (int k = 0; k < 4; k++)
         begin
            cfg_addr = order[k];
            cfg_ctl  = $urandom();
            case (order[k])
               4'd5:    exp_addr[11:0]  = cfg_ctl[31:20];
               4'd9:    exp_addr[31:12] = cfg_ctl[31:12];
               4'd6:    exp_addr[43:32] = cfg_ctl[31:20];
               default: exp_addr[63:44] = cfg_ctl[31:12];
            endcase
            check_outputs("msi_addr");
            step();
         end
         cfg_addr = 4'd2;
         repeat (3)
         begin
            check_outputs("msi_addr");
            step();
         end
         check_val("msi_addr assembled", 256'(exp_addr), 256'(msi_intfc.msi_addr));
      end
      end_test("msi_addr");

      repeat (150)
      begin
         drive_reads(int'($urandom_range(4, 0)));
         check_outputs("read_return");
         step();
      end
      drive_reads(0);
      end_test("read_return");

      repeat (10)
      begin
         cfg_addr = used_codes[$urandom_range(7, 0)];
         cfg_ctl  = $urandom();
         check_outputs("mid_reset");
         step();
      end
      Rstn_i   = 1'b0;
      cfg_addr = '0;
      cfg_ctl  = '0;
      clear_model();
      for (int k = 0; k < 5; k++)
      begin
         check_outputs("mid_reset");
         check_zero("mid_reset");
         step();
         if (k == 2)
            Rstn_i = 1'b1;     // Released after the third edge
      end
      repeat (10)
      begin
         cfg_addr = used_codes[$urandom_range(7, 0)];
         cfg_ctl  = $urandom();
         check_outputs("mid_reset");
         step();
      end
      end_test("mid_reset");

      $display("Tests run %0d, failed %0d, checks %0d, mismatches %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
